//--- bench/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// ------------------------------------------------------------------------
// Reporting and the one compare
// ------------------------------------------------------------------------

task automatic report_error(input string msg);
  $display("Error at %0t: %s", $time, msg);
  $display("FAIL: see errors above");
  $fatal(1);
endtask

task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                        input string msg);
  if (got !== exp) begin
    $display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    $display("FAIL: see errors above");
    $fatal(1);
  end
endtask

// Read data tag, spread over the whole beat
function automatic logic [DATA_W-1:0] read_tag(input logic [ADDR_W-1:0] a);
  return {8{32'(a) ^ 32'h5a5a_0000}};
endfunction

// ------------------------------------------------------------------------
// Queue pushes, each records its expected item
// ------------------------------------------------------------------------

task automatic push_read(input logic [QADDR_W-1:0] a);
  rq_mem[rq_tail] = a;
  rq_tail = rq_tail + PTR_W'(1);
  exp_rd.push_back(a);
endtask

task automatic push_write(input logic [QADDR_W-1:0] a);
  wq_mem[wq_tail] = a;
  wq_tail = wq_tail + PTR_W'(1);
  exp_wr.push_back(a);
endtask

task automatic push_beat();
  logic [DATA_W-1:0] d;
  for (int k = 0; k < 8; k++) d[k*32 +: 32] = $random(seed);
  dq_mem[dq_tail] = d;
  dq_tail = dq_tail + PTR_W'(1);
  exp_beats.push_back(d);
endtask

task automatic quiet_outputs(input string when);
  check_eq(CW'(app_en), '0, {"app_en ", when});
  check_eq(CW'(app_wdf_wren), '0, {"app_wdf_wren ", when});
  check_eq(CW'(raddr_pop), '0, {"raddr_pop ", when});
  check_eq(CW'(waddr_pop), '0, {"waddr_pop ", when});
  check_eq(CW'(wdata_pop), '0, {"wdata_pop ", when});
  check_eq(CW'(rdata_valid), '0, {"rdata_valid ", when});
endtask

// Wait for every expected item, then compare against the push order
task automatic run_checks(input string name);
  int n_cmd;
  int ri;
  int wi;
  int run;
  n_cmd = exp_rd.size() + exp_wr.size();
  for (int c = 0; c < TEST_CYCLES; c++) begin
    @(posedge clk);
    if (cmd_ops.size() >= n_cmd && beat_data.size() >= exp_beats.size() &&
        rd_got.size() >= exp_rd.size()) break;
    if (c == TEST_CYCLES - 1) report_error({name, ": timed out waiting for DUT traffic"});
  end
  // Room for anything duplicated
  repeat (8) @(posedge clk);
  check_eq(CW'(cmd_ops.size()), CW'(n_cmd), {name, ": command count"});
  check_eq(CW'(beat_data.size()), CW'(exp_beats.size()), {name, ": beat count"});
  check_eq(CW'(rd_got.size()), CW'(exp_rd.size()), {name, ": read data count"});
  ri  = 0;
  wi  = 0;
  run = 0;
  for (int i = 0; i < n_cmd; i++) begin
    run = (i > 0 && cmd_ops[i] == cmd_ops[i-1]) ? run + 1 : 1;
    // Runs of one op only matter while both sides have work
    if (ri < exp_rd.size() && wi < exp_wr.size())
      check_eq(CW'(run <= SLICE), CW'(1'b1), {name, ": run longer than a slice"});
    if (cmd_ops[i] == CMD_READ) begin
      check_eq(CW'(cmd_addrs[i]), CW'(exp_rd[ri][ADDR_W-1:0]), {name, ": read address"});
      ri++;
    end else begin
      check_eq(CW'(cmd_ops[i]), CW'(CMD_WRITE), {name, ": command code"});
      check_eq(CW'(cmd_addrs[i]), CW'(exp_wr[wi][ADDR_W-1:0]), {name, ": write address"});
      wi++;
    end
  end
  for (int i = 0; i < exp_beats.size(); i++) begin
    check_eq(beat_data[i], exp_beats[i], {name, ": beat data"});
    check_eq(CW'(beat_end[i]), CW'(i % BEATS_PER_BURST == BEATS_PER_BURST - 1),
             {name, ": burst end flag"});
  end
  for (int i = 0; i < exp_rd.size(); i++)
    check_eq(rd_got[i], read_tag(exp_rd[i][ADDR_W-1:0]), {name, ": read data"});
  cmd_ops.delete();
  cmd_addrs.delete();
  beat_data.delete();
  beat_end.delete();
  rd_got.delete();
  exp_rd.delete();
  exp_wr.delete();
  exp_beats.delete();
endtask

// ------------------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------------------

task automatic test_reset();
  @(negedge clk);
  quiet_outputs("in reset");
  @(negedge clk);
  quiet_outputs("in reset");
  @(posedge clk);
  #1;
  rst_n = 1'b1;
  // Empty queues, nothing may move
  repeat (10) begin
    @(negedge clk);
    quiet_outputs("idle after reset");
  end
endtask

task automatic test_reads_only();
  @(posedge clk);
  #1;
  // Bit 29 set on some, the controller never sees it
  for (int i = 0; i < 6; i++) push_read(QADDR_W'(32'h2000_0040 * (i % 2) + 32'h100 * i + 8));
  run_checks("reads only");
endtask

task automatic test_writes_only();
  @(posedge clk);
  #1;
  for (int i = 0; i < 5; i++) begin
    push_write(QADDR_W'(32'h0300_0000 + 32'h40 * i));
    push_beat();
    push_beat();
  end
  run_checks("writes only");
endtask

task automatic test_two_beat_gate();
  @(posedge clk);
  #1;
  push_write(QADDR_W'(32'h0123_4560));
  push_beat();
  repeat (50) @(posedge clk);
  check_eq(CW'(cmd_ops.size()), '0, "write issued with one beat queued");
  #1;
  push_beat();
  run_checks("two beat gate");
endtask

task automatic test_slicing();
  @(posedge clk);
  #1;
  for (int i = 0; i < 2 * SLICE; i++) begin
    push_read(QADDR_W'(32'h0040_0000 + 32'h20 * i));
    push_write(QADDR_W'(32'h0080_0000 + 32'h20 * i));
    push_beat();
    push_beat();
  end
  run_checks("slicing");
endtask

task automatic test_back_pressure();
  // Random ready lines from the next drive point on
  rand_rdy = 1'b1;
  @(posedge clk);
  #1;
  for (int i = 0; i < 10; i++) begin
    push_read(QADDR_W'($random(seed)));
    push_write(QADDR_W'($random(seed)));
    push_beat();
    push_beat();
  end
  run_checks("back-pressure");
  rand_rdy = 1'b0;
endtask

`endif

//--- bench/tb_ddr_app.sv
`timescale 1ns/10ps

module tb_ddr_app;

  import ddr_arb_pkg::*;

  localparam int SLICE       = 4;
  localparam int TURN        = 2;
  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 3000;
  localparam int PTR_W       = 10;
  localparam int CW          = DATA_W;

  logic              clk;
  logic              rst_n;
  logic [QADDR_W-1:0] raddr_dout;
  logic              raddr_empty;
  logic              raddr_pop;
  logic [QADDR_W-1:0] waddr_dout;
  logic              waddr_empty;
  logic              waddr_pop;
  logic [DATA_W-1:0] wdata_dout;
  logic [LEVEL_W-1:0] wdata_level;
  logic              wdata_pop;
  logic [DATA_W-1:0] rdata;
  logic              rdata_valid;
  logic              app_rdy;
  logic              app_wdf_rdy;
  logic [DATA_W-1:0] app_rd_data;
  logic              app_rd_data_valid;
  logic              app_en;
  logic [2:0]        app_cmd;
  logic [ADDR_W-1:0] app_addr;
  logic              app_wdf_wren;
  logic [DATA_W-1:0] app_wdf_data;
  logic              app_wdf_end;

  // ----------------------------------------------------------------------
  // Queue storage, show-ahead heads
  // ----------------------------------------------------------------------

  logic [QADDR_W-1:0] rq_mem [2**PTR_W];
  logic [QADDR_W-1:0] wq_mem [2**PTR_W];
  logic [DATA_W-1:0]  dq_mem [2**PTR_W];
  logic [PTR_W-1:0]   rq_head;
  logic [PTR_W-1:0]   rq_tail;
  logic [PTR_W-1:0]   wq_head;
  logic [PTR_W-1:0]   wq_tail;
  logic [PTR_W-1:0]   dq_head;
  logic [PTR_W-1:0]   dq_tail;
  logic               rpop_seen;
  logic               wpop_seen;
  logic               dpop_seen;

  // Controller model records and read returns
  logic [2:0]        cmd_ops [$];
  logic [ADDR_W-1:0] cmd_addrs [$];
  logic [DATA_W-1:0] beat_data [$];
  logic              beat_end [$];
  logic [DATA_W-1:0] rd_got [$];
  logic [ADDR_W-1:0] ret_q [$];

  // Expected streams, filled by the push helpers
  logic [QADDR_W-1:0] exp_rd [$];
  logic [QADDR_W-1:0] exp_wr [$];
  logic [DATA_W-1:0]  exp_beats [$];

  int          seed;
  logic        rand_rdy;
  logic [31:0] rnd;
  logic        cmd_held;
  logic [2:0]  held_op;
  logic [ADDR_W-1:0] held_addr;
  logic        beat_held;
  logic [DATA_W-1:0] held_data;
  logic        held_end;

  assign raddr_empty = (rq_head == rq_tail);
  assign raddr_dout  = rq_mem[rq_head];
  assign waddr_empty = (wq_head == wq_tail);
  assign waddr_dout  = wq_mem[wq_head];
  assign wdata_dout  = dq_mem[dq_head];
  assign wdata_level = LEVEL_W'(dq_tail - dq_head);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ddr_app_top #(
    .SLICE_BURSTS (SLICE),
    .TURN_CYCLES  (TURN)
  ) i_ddr_app_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .raddr_dout        (raddr_dout),
    .raddr_empty       (raddr_empty),
    .raddr_pop         (raddr_pop),
    .waddr_dout        (waddr_dout),
    .waddr_empty       (waddr_empty),
    .waddr_pop         (waddr_pop),
    .wdata_dout        (wdata_dout),
    .wdata_level       (wdata_level),
    .wdata_pop         (wdata_pop),
    .rdata             (rdata),
    .rdata_valid       (rdata_valid),
    .app_rdy           (app_rdy),
    .app_wdf_rdy       (app_wdf_rdy),
    .app_rd_data       (app_rd_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_en            (app_en),
    .app_cmd           (app_cmd),
    .app_addr          (app_addr),
    .app_wdf_wren      (app_wdf_wren),
    .app_wdf_data      (app_wdf_data),
    .app_wdf_end       (app_wdf_end)
  );

  `include "tb_tests.svh"

  // ----------------------------------------------------------------------
  // Monitor at the falling edge, where DUT outputs are settled
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    rpop_seen = raddr_pop;
    wpop_seen = waddr_pop;
    dpop_seen = wdata_pop;
    if (rst_n) begin
      if (raddr_pop && raddr_empty) report_error("read-address pop while its queue is empty");
      if (waddr_pop && waddr_empty) report_error("write-address pop while its queue is empty");
      if (dpop_seen && dq_head == dq_tail) report_error("write-data pop while its queue is empty");
      // Held command and beat must not move
      if (cmd_held) begin
        check_eq(CW'(app_en), CW'(1'b1), "app_en dropped while held");
        check_eq(CW'(app_cmd), CW'(held_op), "app_cmd changed while held");
        check_eq(CW'(app_addr), CW'(held_addr), "app_addr changed while held");
      end
      if (beat_held) begin
        check_eq(CW'(app_wdf_wren), CW'(1'b1), "app_wdf_wren dropped while held");
        check_eq(app_wdf_data, held_data, "app_wdf_data changed while held");
        check_eq(CW'(app_wdf_end), CW'(held_end), "app_wdf_end changed while held");
      end
      if (app_en && app_rdy) begin
        cmd_ops.push_back(app_cmd);
        cmd_addrs.push_back(app_addr);
        if (app_cmd == CMD_READ) ret_q.push_back(app_addr);
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        beat_data.push_back(app_wdf_data);
        beat_end.push_back(app_wdf_end);
      end
      // Zero-latency pass-through
      check_eq(CW'(rdata_valid), CW'(app_rd_data_valid), "rdata_valid pass-through");
      if (app_rd_data_valid) begin
        check_eq(rdata, app_rd_data, "rdata pass-through");
        rd_got.push_back(rdata);
      end
    end
    cmd_held  = app_en && !app_rdy;
    held_op   = app_cmd;
    held_addr = app_addr;
    beat_held = app_wdf_wren && !app_wdf_rdy;
    held_data = app_wdf_data;
    held_end  = app_wdf_end;
  end

  // Queue heads, ready lines and read returns, just after the edge
  always @(posedge clk) begin
    #1;
    if (rpop_seen) rq_head = rq_head + PTR_W'(1);
    if (wpop_seen) wq_head = wq_head + PTR_W'(1);
    if (dpop_seen) dq_head = dq_head + PTR_W'(1);
    rpop_seen = 1'b0;
    wpop_seen = 1'b0;
    dpop_seen = 1'b0;
    if (rand_rdy) begin
      rnd         = $random(seed);
      app_rdy     = rnd[0];
      app_wdf_rdy = rnd[1];
    end else begin
      app_rdy     = 1'b1;
      app_wdf_rdy = 1'b1;
    end
    if (ret_q.size() > 0) begin
      app_rd_data_valid = 1'b1;
      app_rd_data       = read_tag(ret_q.pop_front());
    end else begin
      app_rd_data_valid = 1'b0;
      app_rd_data       = '0;
    end
  end

  // Watchdog sized for every test at its own budget
  initial begin
    #(TEST_CYCLES * NUM_TESTS * CLK_PERIOD);
    $display("Error: watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    seed              = 32'h4ab8_bd37;
    clk               = 1'b0;
    rst_n             = 1'b0;
    rand_rdy          = 1'b0;
    app_rdy           = 1'b1;
    app_wdf_rdy       = 1'b1;
    app_rd_data       = '0;
    app_rd_data_valid = 1'b0;
    rq_head = '0;
    rq_tail = '0;
    wq_head = '0;
    wq_tail = '0;
    dq_head = '0;
    dq_tail = '0;
    rpop_seen = 1'b0;
    wpop_seen = 1'b0;
    dpop_seen = 1'b0;
    cmd_held  = 1'b0;
    beat_held = 1'b0;
    test_reset();
    test_reads_only();
    test_writes_only();
    test_two_beat_gate();
    test_slicing();
    test_back_pressure();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- design/cmd_issue.sv
`timescale 1ns/10ps

module cmd_issue (
  input  logic                              clk,
  input  logic                              rst_n,
  input  ddr_arb_pkg::grant_t               grant,
  // Read-address queue, show-ahead
  input  logic [ddr_arb_pkg::QADDR_W-1:0]   raddr,
  input  logic                              raddr_empty,
  output logic                              raddr_pop,
  // Write-address queue, show-ahead
  input  logic [ddr_arb_pkg::QADDR_W-1:0]   waddr,
  input  logic                              waddr_empty,
  output logic                              waddr_pop,
  // Write-data queue fill
  input  logic [ddr_arb_pkg::LEVEL_W-1:0]   wdata_level,
  output logic                              wr_pending,
  // Into the command hold register
  output logic                              cmd_valid,
  output ddr_arb_pkg::ddr_cmd_t             cmd,
  input  logic                              cmd_ready,
  // Side pulses
  output logic                              cmd_taken,
  output logic                              burst_start
);

  import ddr_arb_pkg::*;

  logic may_issue;
  logic rd_go;
  logic wr_go;

  // ---------------------------------------------------------------------
  // Issue conditions
  // ---------------------------------------------------------------------

  // Write needs an address and a full burst of beats
  // Shared with the arbiter for its idle/waiting view
  assign wr_pending = !waddr_empty &&
                      (wdata_level >= LEVEL_W'(BEATS_PER_BURST));

  assign may_issue = grant.open && cmd_ready;
  assign rd_go     = may_issue && (grant.mode == MODE_READ) && !raddr_empty;
  assign wr_go     = may_issue && (grant.mode == MODE_WRITE) && wr_pending;

  // Pop and push in the same cycle
  assign raddr_pop = rd_go;
  assign waddr_pop = wr_go;
  assign cmd_valid = rd_go || wr_go;

  // ---------------------------------------------------------------------
  // Command build
  // ---------------------------------------------------------------------

  // Head entry of the queue for the current side
  always_comb begin
    cmd.op   = CMD_READ;
    cmd.addr = raddr[ADDR_W-1:0];
    if (grant.mode == MODE_WRITE) begin
      cmd.op   = CMD_WRITE;
      cmd.addr = waddr[ADDR_W-1:0];
    end
  end

  // Slice count and beat owed count
  assign cmd_taken   = cmd_valid && cmd_ready;
  assign burst_start = wr_go;

  // ---------------------------------------------------------------------
  // Queue protocol checks
  // ---------------------------------------------------------------------

  // Show-ahead head holds until popped
  a_raddr_head : assert property (
    @(posedge clk) disable iff (!rst_n)
    !raddr_empty && !raddr_pop |=> !raddr_empty && $stable(raddr)
  );

  a_waddr_head : assert property (
    @(posedge clk) disable iff (!rst_n)
    !waddr_empty && !waddr_pop |=> !waddr_empty && $stable(waddr)
  );

endmodule

//--- design/ddr_app_top.sv
`timescale 1ns/10ps

module ddr_app_top #(
  parameter int SLICE_BURSTS = 32,
  parameter int TURN_CYCLES  = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  // Read-address queue
  input  logic [ddr_arb_pkg::QADDR_W-1:0]  raddr_dout,
  input  logic                             raddr_empty,
  output logic                             raddr_pop,
  // Write-address queue
  input  logic [ddr_arb_pkg::QADDR_W-1:0]  waddr_dout,
  input  logic                             waddr_empty,
  output logic                             waddr_pop,
  // Write-data queue
  input  logic [ddr_arb_pkg::DATA_W-1:0]   wdata_dout,
  input  logic [ddr_arb_pkg::LEVEL_W-1:0]  wdata_level,
  output logic                             wdata_pop,
  // Read data out
  output logic [ddr_arb_pkg::DATA_W-1:0]   rdata,
  output logic                             rdata_valid,
  // DDR controller app port
  input  logic                             app_rdy,
  input  logic                             app_wdf_rdy,
  input  logic [ddr_arb_pkg::DATA_W-1:0]   app_rd_data,
  input  logic                             app_rd_data_valid,
  output logic                             app_en,
  output logic [2:0]                       app_cmd,
  output logic [ddr_arb_pkg::ADDR_W-1:0]   app_addr,
  output logic                             app_wdf_wren,
  output logic [ddr_arb_pkg::DATA_W-1:0]   app_wdf_data,
  output logic                             app_wdf_end
);

  import ddr_arb_pkg::*;

  grant_t    grant;
  logic      wr_pending;
  logic      cmd_valid;
  logic      cmd_ready;
  logic      cmd_taken;
  logic      burst_start;
  ddr_cmd_t  cmd;
  ddr_cmd_t  cmd_q;
  logic      beat_valid;
  logic      beat_ready;
  wdf_beat_t beat;
  wdf_beat_t beat_q;

  // ---------------------------------------------------------------------
  // Arbiter, busy while a command sits in the hold register
  // ---------------------------------------------------------------------

  slice_arbiter #(
    .SLICE_BURSTS (SLICE_BURSTS),
    .TURN_CYCLES  (TURN_CYCLES)
  ) i_slice_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_empty   (raddr_empty),
    .wr_pending (wr_pending),
    .cmd_taken  (cmd_taken),
    .cmd_busy   (app_en),
    .grant      (grant)
  );

  // Command issue
  cmd_issue i_cmd_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .grant       (grant),
    .raddr       (raddr_dout),
    .raddr_empty (raddr_empty),
    .raddr_pop   (raddr_pop),
    .waddr       (waddr_dout),
    .waddr_empty (waddr_empty),
    .waddr_pop   (waddr_pop),
    .wdata_level (wdata_level),
    .wr_pending  (wr_pending),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .cmd_taken   (cmd_taken),
    .burst_start (burst_start)
  );

  // Command hold stage toward app_en/app_rdy
  ddr_hold_reg #(
    .payload_t (ddr_cmd_t)
  ) i_cmd_hold (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (cmd_valid),
    .in_data   (cmd),
    .in_ready  (cmd_ready),
    .out_valid (app_en),
    .out_data  (cmd_q),
    .out_ready (app_rdy)
  );

  // ---------------------------------------------------------------------
  // Write beats, parallel to the command path
  // ---------------------------------------------------------------------

  wdata_beats i_wdata_beats (
    .clk         (clk),
    .rst_n       (rst_n),
    .burst_start (burst_start),
    .wdata       (wdata_dout),
    .wdata_pop   (wdata_pop),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .beat_ready  (beat_ready)
  );

  ddr_hold_reg #(
    .payload_t (wdf_beat_t)
  ) i_beat_hold (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (beat_valid),
    .in_data   (beat),
    .in_ready  (beat_ready),
    .out_valid (app_wdf_wren),
    .out_data  (beat_q),
    .out_ready (app_wdf_rdy)
  );

  // Unpack held payloads onto the app port
  assign app_cmd      = cmd_q.op;
  assign app_addr     = cmd_q.addr;
  assign app_wdf_data = beat_q.data;
  assign app_wdf_end  = beat_q.burst_end;

  // Read return passes straight through
  assign rdata       = app_rd_data;
  assign rdata_valid = app_rd_data_valid;

endmodule

//--- design/ddr_arb_pkg.sv
package ddr_arb_pkg;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------

  // Controller command address
  localparam int ADDR_W = 29;
  // Address queue entry, upper bit unused by the controller
  localparam int QADDR_W = 30;
  // One half-rate data beat
  localparam int DATA_W = 256;
  // BL8 on a half-rate port gives two beats per command
  localparam int BEATS_PER_BURST = 2;
  // Write-data queue fill level
  localparam int LEVEL_W = 9;

  // ---------------------------------------------------------------------
  // Controller command codes
  // ---------------------------------------------------------------------

  localparam logic [2:0] CMD_WRITE = 3'd0;
  localparam logic [2:0] CMD_READ  = 3'd1;

  // ---------------------------------------------------------------------
  // Shared types
  // ---------------------------------------------------------------------

  // Current slice direction
  typedef enum logic {
    MODE_READ  = 1'b0,
    MODE_WRITE = 1'b1
  } ddr_mode_e;

  // One command for the app port, 32 bits
  typedef struct packed {
    logic [2:0]        op;
    logic [ADDR_W-1:0] addr;
  } ddr_cmd_t;

  // One write beat plus its burst end mark, 257 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              burst_end;
  } wdf_beat_t;

  // Arbiter decision, open means commands may go out now
  typedef struct packed {
    ddr_mode_e mode;
    logic      open;
  } grant_t;

endpackage

//--- design/ddr_hold_reg.sv
`timescale 1ns/10ps

module ddr_hold_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  // Upstream side
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  // Downstream side
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic load;

  // Room when empty or when the held entry leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  // ---------------------------------------------------------------------
  // Occupancy
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // Drained with nothing behind it
      out_valid <= 1'b0;
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Stalled entry must stay put until the consumer takes it
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

//--- design/slice_arbiter.sv
`timescale 1ns/10ps

module slice_arbiter #(
  parameter int SLICE_BURSTS = 32,
  parameter int TURN_CYCLES  = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  // Work indications
  input  logic                rd_empty,
  input  logic                wr_pending,
  // Command path status
  input  logic                cmd_taken,
  input  logic                cmd_busy,
  output ddr_arb_pkg::grant_t grant
);

  import ddr_arb_pkg::*;

  localparam int CNT_W  = $clog2(SLICE_BURSTS + 1);
  localparam int TURN_W = (TURN_CYCLES > 0) ? $clog2(TURN_CYCLES + 1) : 1;

  ddr_mode_e         mode;
  logic [CNT_W-1:0]  slice_cnt;
  logic [TURN_W-1:0] turn_cnt;

  logic own_idle;
  logic other_busy;
  logic slice_done;
  logic turning;
  logic switch_now;

  // ---------------------------------------------------------------------
  // Switch decision
  // ---------------------------------------------------------------------

  // Idle and waiting flags seen from the current side
  always_comb begin
    if (mode == MODE_READ) begin
      own_idle   = rd_empty;
      other_busy = wr_pending;
    end else begin
      own_idle   = !wr_pending;
      other_busy = !rd_empty;
    end
  end

  assign slice_done = (slice_cnt == CNT_W'(SLICE_BURSTS));
  assign turning    = (turn_cnt != '0);

  // Only with the hold register drained, so no old-mode command is in flight
  // Never during a gap, avoids ping-pong
  assign switch_now = (slice_done || own_idle) && other_busy && !cmd_busy && !turning;

  // ---------------------------------------------------------------------
  // Mode, slice count and turnaround gap
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode <= MODE_READ;
    end else if (switch_now) begin
      mode <= (mode == MODE_READ) ? MODE_WRITE : MODE_READ;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slice_cnt <= '0;
    end else if (switch_now) begin
      slice_cnt <= '0;
    end else if (slice_done && !other_busy) begin
      // Nobody waiting, start a fresh slice on the same side
      slice_cnt <= '0;
    end else if (cmd_taken) begin
      slice_cnt <= slice_cnt + 1'b1;
    end
  end

  // Gap of TURN_CYCLES closed cycles after each switch edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      turn_cnt <= '0;
    end else if (switch_now) begin
      turn_cnt <= TURN_W'(TURN_CYCLES);
    end else if (turning) begin
      turn_cnt <= turn_cnt - 1'b1;
    end
  end

  // Closed in the gap and once the slice is used up
  // cmd_busy is already low at the switch and nothing is pushed in the gap
  assign grant.mode = mode;
  assign grant.open = !turning && !slice_done;

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Issue stage must respect the grant
  a_taken_open : assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_taken |-> grant.open
  );

endmodule

//--- design/wdata_beats.sv
`timescale 1ns/10ps

module wdata_beats (
  input  logic                             clk,
  input  logic                             rst_n,
  // One pulse per write command
  input  logic                             burst_start,
  // Write-data queue head, show-ahead
  input  logic [ddr_arb_pkg::DATA_W-1:0]   wdata,
  output logic                             wdata_pop,
  // Into the beat hold register
  output logic                             beat_valid,
  output ddr_arb_pkg::wdf_beat_t           beat,
  input  logic                             beat_ready
);

  import ddr_arb_pkg::*;

  localparam int PHASE_W = (BEATS_PER_BURST > 1) ? $clog2(BEATS_PER_BURST) : 1;

  // Bursts whose beats are still queued
  logic [LEVEL_W-1:0] owed;
  // Beat index inside the current burst
  logic [PHASE_W-1:0] phase;

  logic last_beat;
  logic burst_done;

  assign last_beat  = (phase == PHASE_W'(BEATS_PER_BURST - 1));
  // One beat per cycle while anything is owed and there is room
  assign wdata_pop  = (owed != '0) && beat_ready;
  assign burst_done = wdata_pop && last_beat;

  assign beat_valid     = wdata_pop;
  assign beat.data      = wdata;
  assign beat.burst_end = last_beat;

  // ---------------------------------------------------------------------
  // Burst bookkeeping
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (wdata_pop) begin
      phase <= last_beat ? '0 : phase + 1'b1;
    end
  end

  // New burst and finished burst may land on the same edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owed <= '0;
    end else begin
      case ({burst_start, burst_done})
        2'b10:   owed <= owed + 1'b1;
        2'b01:   owed <= owed - 1'b1;
        default: owed <= owed;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Nothing owed, so no burst may be half popped
  a_idle_phase : assert property (
    @(posedge clk) disable iff (!rst_n)
    (owed == '0) |-> (phase == '0)
  );

  // Owed counter wrap
  a_owed_wrap : assert property (
    @(posedge clk) disable iff (!rst_n)
    burst_start && !burst_done |-> (owed != '1)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the ddr_app_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ddr_app -f sources.f \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_ddr_app > sim.log 2>&1 || true
cat sim.log

grep -qx "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+bench
design/ddr_arb_pkg.sv
design/ddr_hold_reg.sv
design/slice_arbiter.sv
design/cmd_issue.sv
design/wdata_beats.sv
design/ddr_app_top.sv
bench/tb_ddr_app.sv
